// ==== source/breakout_defs.svh ====
`ifndef BREAKOUT_DEFS_SVH
`define BREAKOUT_DEFS_SVH

// playfield size in pixels
`define SCREEN_WIDTH 160
`define SCREEN_HEIGHT 120

// paddle geometry, the paddle lives on a single row
`define PADDLE_WIDTH 20
`define PADDLE_ROW 100
`define PADDLE_MIN 1
`define PADDLE_MAX 139
`define PADDLE_START 70

// ball restart point, one row above the paddle
`define BALL_START_X 79
`define BALL_START_Y 99

`define START_LIVES 3

// PS/2 set 2 scan codes
`define KEY_SPACE 8'h29
`define KEY_LEFT 8'h1C
`define KEY_RIGHT 8'h23
`define KEY_BREAK 8'hF0

// 3-bit rgb pixel values
`define COLOUR_BLACK 3'd0
`define COLOUR_PADDLE 3'd5
`define COLOUR_BALL 3'd7

`endif

// ==== source/playfieldPkg.sv ====
package playfieldPkg;

    // column, 0 to 159
    typedef logic [7:0] coordX;

    // row, 0 to 119
    typedef logic [6:0] coordY;

    // frame buffer word address, row * 160 + column
    typedef logic [14:0] pixelAddress;

    // rgb, one bit per channel
    typedef logic [2:0] colour;

endpackage

// ==== source/controlPkg.sv ====
package controlPkg;

    // raw PS/2 byte or the key currently held
    typedef logic [7:0] scanCode;

    // paddle hits so far
    typedef logic [5:0] scoreCount;

    typedef logic [1:0] lifeCount;

    typedef enum logic [1:0]
    {
        stateMenu,
        statePlay,
        stateWin,
        stateLoss
    } gameState;

endpackage

// ==== source/keyDecoder.sv ====
`timescale 1ns/10ps
`include "breakout_defs.svh"

module keyDecoder (
    input  logic                clock,
    input  logic                reset,
    input  controlPkg::scanCode scanByte,
    input  logic                scanValid,
    output controlPkg::scanCode heldKey
);

    // set by F0, the next byte names the released key
    logic breakPending;

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            heldKey <= '0;
            breakPending <= 1'b0;
        end
        else if (scanValid)
        begin
            if (breakPending)
            begin
                // release of some other key leaves the held one alone
                if (scanByte == heldKey)
                    heldKey <= '0;
                breakPending <= 1'b0;
            end
            else if (scanByte == `KEY_BREAK)
                breakPending <= 1'b1;
            else
                heldKey <= scanByte;
        end
    end

endmodule

// ==== source/frameTimer.sv ====
`timescale 1ns/10ps

module frameTimer #(
    parameter int frameCycles = 833333
) (
    input  logic clock,
    input  logic reset,
    output logic frameTick
);

    localparam int counterWidth = (frameCycles > 1) ? $clog2(frameCycles) : 1;
    localparam logic [counterWidth-1:0] lastCount = counterWidth'(frameCycles - 1);

    logic [counterWidth-1:0] cycleCount;

    always_ff @(posedge clock)
    begin
        if (!reset)
            cycleCount <= '0;
        else if (cycleCount == lastCount)
            cycleCount <= '0;
        else
            cycleCount <= cycleCount + 1'b1;
    end

    // one cycle wide, on the last count of the period
    assign frameTick = (cycleCount == lastCount);

endmodule

// ==== source/paddleMotion.sv ====
`timescale 1ns/10ps
`include "breakout_defs.svh"

module paddleMotion (
    input  logic                clock,
    input  logic                reset,
    input  logic                frameTick,
    input  logic                playing,
    input  controlPkg::scanCode heldKey,
    output playfieldPkg::coordX paddleX
);

    localparam playfieldPkg::coordX leftLimit = playfieldPkg::coordX'(`PADDLE_MIN);
    localparam playfieldPkg::coordX rightLimit = playfieldPkg::coordX'(`PADDLE_MAX);

    always_ff @(posedge clock)
    begin
        if (!reset)
            paddleX <= playfieldPkg::coordX'(`PADDLE_START);
        else if (frameTick && playing)
        begin
            // one column per frame, stops at the walls
            if (heldKey == `KEY_RIGHT && paddleX < rightLimit)
                paddleX <= paddleX + 1'b1;
            else if (heldKey == `KEY_LEFT && paddleX > leftLimit)
                paddleX <= paddleX - 1'b1;
        end
    end

    paddleInRange: assert property (@(posedge clock) disable iff (!reset)
        paddleX >= leftLimit && paddleX <= rightLimit);

endmodule

// ==== source/ballMotion.sv ====
`timescale 1ns/10ps
`include "breakout_defs.svh"

module ballMotion (
    input  logic                clock,
    input  logic                reset,
    input  logic                frameTick,
    input  logic                playing,
    input  playfieldPkg::coordX paddleX,
    output playfieldPkg::coordX ballX,
    output playfieldPkg::coordY ballY,
    output logic                paddleHit,
    output logic                ballLost
);

    localparam playfieldPkg::coordX rightWall = playfieldPkg::coordX'(`SCREEN_WIDTH - 1);
    localparam playfieldPkg::coordY bottomRow = playfieldPkg::coordY'(`SCREEN_HEIGHT - 1);
    // row just above the paddle, where a bounce can happen
    localparam playfieldPkg::coordY approachRow = playfieldPkg::coordY'(`PADDLE_ROW - 1);

    logic movingLeft;
    logic movingUp;
    logic nextLeft;
    logic nextUp;
    logic hitNow;
    logic missNow;
    logic [8:0] paddleRight;
    playfieldPkg::coordX nextX;
    playfieldPkg::coordY nextY;

    assign paddleRight = {1'b0, paddleX} + 9'(`PADDLE_WIDTH - 1);
    assign missNow = !movingUp && ballY == bottomRow;

    always_comb
    begin
        // flip at a wall first, then take the step
        nextLeft = movingLeft ? (ballX != '0) : (ballX == rightWall);
        nextX = nextLeft ? ballX - 1'b1 : ballX + 1'b1;
        hitNow = !movingUp && ballY == approachRow
            && {1'b0, nextX} >= {1'b0, paddleX} && {1'b0, nextX} <= paddleRight;
        nextUp = movingUp ? (ballY != '0) : hitNow;
        nextY = nextUp ? ballY - 1'b1 : ballY + 1'b1;
    end

    // ball parks at the start point outside play and after a miss
    always_ff @(posedge clock)
    begin
        if (!reset || !playing || (frameTick && missNow))
        begin
            ballX <= playfieldPkg::coordX'(`BALL_START_X);
            ballY <= playfieldPkg::coordY'(`BALL_START_Y);
            movingLeft <= 1'b1;
            movingUp <= 1'b1;
        end
        else if (frameTick)
        begin
            ballX <= nextX;
            ballY <= nextY;
            movingLeft <= nextLeft;
            movingUp <= nextUp;
        end
    end

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            paddleHit <= 1'b0;
            ballLost <= 1'b0;
        end
        else
        begin
            paddleHit <= playing && frameTick && hitNow;
            ballLost <= playing && frameTick && missNow;
        end
    end

    ballOnScreen: assert property (@(posedge clock) disable iff (!reset)
        ballX <= rightWall);

    hitOrMiss: assert property (@(posedge clock) disable iff (!reset)
        !(paddleHit && ballLost));

endmodule

// ==== source/gameControl.sv ====
`timescale 1ns/10ps
`include "breakout_defs.svh"

module gameControl #(
    parameter int winScore = 40
) (
    input  logic                  clock,
    input  logic                  reset,
    input  controlPkg::scanCode   heldKey,
    input  logic                  paddleHit,
    input  logic                  ballLost,
    output logic                  playing,
    output controlPkg::gameState  state,
    output controlPkg::scoreCount score,
    output controlPkg::lifeCount  lives
);

    controlPkg::gameState nextState;

    always_comb
    begin
        nextState = state;
        case (state)
            controlPkg::stateMenu:
                if (heldKey == `KEY_SPACE)
                    nextState = controlPkg::statePlay;
            controlPkg::statePlay:
                if (score == controlPkg::scoreCount'(winScore))
                    nextState = controlPkg::stateWin;
                else if (lives == '0)
                    nextState = controlPkg::stateLoss;
            // win and loss hold until reset
            default:
                nextState = state;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            state <= controlPkg::stateMenu;
            score <= '0;
            lives <= controlPkg::lifeCount'(`START_LIVES);
        end
        else
        begin
            state <= nextState;
            if (playing && paddleHit)
                score <= score + 1'b1;
            if (playing && ballLost && lives != '0)
                lives <= lives - 1'b1;
        end
    end

    assign playing = (state == controlPkg::statePlay);

endmodule

// ==== source/pixelWriter.sv ====
`timescale 1ns/10ps
`include "breakout_defs.svh"

module pixelWriter (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      frameTick,
    input  logic                      playing,
    input  playfieldPkg::coordX       paddleX,
    input  playfieldPkg::coordX       ballX,
    input  playfieldPkg::coordY       ballY,
    output logic                      wbCyc,
    output logic                      wbStb,
    output logic                      wbWe,
    output playfieldPkg::pixelAddress wbAdr,
    output playfieldPkg::colour       wbData,
    input  logic                      wbAck
);

    typedef enum logic [2:0]
    {
        phaseIdle,
        phaseEraseBall,
        phaseErasePaddle,
        phaseDrawPaddle,
        phaseDrawBall
    } writePhase;

    localparam playfieldPkg::coordY paddleRow = playfieldPkg::coordY'(`PADDLE_ROW);
    localparam logic [4:0] lastIndex = 5'(`PADDLE_WIDTH - 1);

    writePhase phase;
    logic tickPending;
    logic [4:0] pixelIndex;
    playfieldPkg::coordX snapPaddleX;
    playfieldPkg::coordX snapBallX;
    playfieldPkg::coordY snapBallY;
    playfieldPkg::coordX lastPaddleX;
    playfieldPkg::coordX lastBallX;
    playfieldPkg::coordY lastBallY;

    function automatic playfieldPkg::pixelAddress addressOf(
        input playfieldPkg::coordY row,
        input playfieldPkg::coordX column
    );
        return playfieldPkg::pixelAddress'(row) * playfieldPkg::pixelAddress'(`SCREEN_WIDTH)
            + playfieldPkg::pixelAddress'(column);
    endfunction

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            phase <= phaseIdle;
            tickPending <= 1'b0;
            pixelIndex <= '0;
            lastPaddleX <= playfieldPkg::coordX'(`PADDLE_START);
            lastBallX <= playfieldPkg::coordX'(`BALL_START_X);
            lastBallY <= playfieldPkg::coordY'(`BALL_START_Y);
        end
        else
        begin
            tickPending <= frameTick && playing;
            case (phase)
                // a tick seen mid redraw is dropped
                phaseIdle:
                    if (tickPending)
                        phase <= phaseEraseBall;
                phaseEraseBall:
                    if (wbAck)
                        phase <= phaseErasePaddle;
                phaseErasePaddle, phaseDrawPaddle:
                    if (wbAck)
                    begin
                        if (pixelIndex == lastIndex)
                        begin
                            pixelIndex <= '0;
                            phase <= (phase == phaseErasePaddle) ? phaseDrawPaddle
                                                                  : phaseDrawBall;
                        end
                        else
                            pixelIndex <= pixelIndex + 1'b1;
                    end
                phaseDrawBall:
                    if (wbAck)
                    begin
                        lastPaddleX <= snapPaddleX;
                        lastBallX <= snapBallX;
                        lastBallY <= snapBallY;
                        phase <= phaseIdle;
                    end
                default:
                    phase <= phaseIdle;
            endcase
        end
    end

    // positions as they stood one edge after the frame tick
    always_ff @(posedge clock)
    begin
        if (phase == phaseIdle && tickPending)
        begin
            snapPaddleX <= paddleX;
            snapBallX <= ballX;
            snapBallY <= ballY;
        end
    end

    always_comb
    begin
        case (phase)
            phaseErasePaddle:
            begin
                wbAdr = addressOf(paddleRow, lastPaddleX + playfieldPkg::coordX'(pixelIndex));
                wbData = `COLOUR_BLACK;
            end
            phaseDrawPaddle:
            begin
                wbAdr = addressOf(paddleRow, snapPaddleX + playfieldPkg::coordX'(pixelIndex));
                wbData = `COLOUR_PADDLE;
            end
            phaseDrawBall:
            begin
                wbAdr = addressOf(snapBallY, snapBallX);
                wbData = `COLOUR_BALL;
            end
            default:
            begin
                wbAdr = addressOf(lastBallY, lastBallX);
                wbData = `COLOUR_BLACK;
            end
        endcase
    end

    // one cycle spans the whole redraw
    assign wbCyc = (phase != phaseIdle);
    assign wbStb = (phase != phaseIdle);
    assign wbWe = (phase != phaseIdle);

    // the cycle only closes on the ack of the last write
    cycEndsOnAck: assert property (@(posedge clock) disable iff (!reset)
        $fell(wbCyc) |-> $past(wbAck));

    writeHeld: assert property (@(posedge clock) disable iff (!reset)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbData)));

endmodule

// ==== source/breakoutCore.sv ====
`timescale 1ns/10ps

module breakoutCore #(
    parameter int frameCycles = 833333,
    parameter int winScore = 40
) (
    input  logic                      clock,
    input  logic                      reset,
    input  controlPkg::scanCode       scanByte,
    input  logic                      scanValid,
    output controlPkg::gameState      state,
    output controlPkg::scoreCount     score,
    output controlPkg::lifeCount      lives,
    output logic                      wbCyc,
    output logic                      wbStb,
    output logic                      wbWe,
    output playfieldPkg::pixelAddress wbAdr,
    output playfieldPkg::colour       wbData,
    input  logic                      wbAck
);

    controlPkg::scanCode heldKey;
    logic frameTick;
    logic playing;
    logic paddleHit;
    logic ballLost;
    playfieldPkg::coordX paddleX;
    playfieldPkg::coordX ballX;
    playfieldPkg::coordY ballY;

    keyDecoder keys (
        .clock(clock),
        .reset(reset),
        .scanByte(scanByte),
        .scanValid(scanValid),
        .heldKey(heldKey)
    );

    frameTimer #(.frameCycles(frameCycles)) timer (
        .clock(clock),
        .reset(reset),
        .frameTick(frameTick)
    );

    gameControl #(.winScore(winScore)) control (
        .clock(clock),
        .reset(reset),
        .heldKey(heldKey),
        .paddleHit(paddleHit),
        .ballLost(ballLost),
        .playing(playing),
        .state(state),
        .score(score),
        .lives(lives)
    );

    paddleMotion paddle (
        .clock(clock),
        .reset(reset),
        .frameTick(frameTick),
        .playing(playing),
        .heldKey(heldKey),
        .paddleX(paddleX)
    );

    ballMotion ball (
        .clock(clock),
        .reset(reset),
        .frameTick(frameTick),
        .playing(playing),
        .paddleX(paddleX),
        .ballX(ballX),
        .ballY(ballY),
        .paddleHit(paddleHit),
        .ballLost(ballLost)
    );

    // Wishbone master toward the external frame buffer
    pixelWriter writer (
        .clock(clock),
        .reset(reset),
        .frameTick(frameTick),
        .playing(playing),
        .paddleX(paddleX),
        .ballX(ballX),
        .ballY(ballY),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbData(wbData),
        .wbAck(wbAck)
    );

endmodule

// ==== dv/breakoutTests.svh ====
// directed tests and their bus helpers, included inside breakoutCoreTb

task automatic applyReset();
    int i;
    @(posedge clock);
    reset <= 1'b0;
    scanValid <= 1'b0;
    for (i = 0; i < 5; i++)
        @(posedge clock);
    reset <= 1'b1;
    logAdr.delete();
    logData.delete();
    resetModel();
endtask

task automatic sendByte(input controlPkg::scanCode value);
    @(posedge clock);
    scanByte <= value;
    scanValid <= 1'b1;
    @(posedge clock);
    scanValid <= 1'b0;
endtask

task automatic pressKey(input controlPkg::scanCode key);
    sendByte(key);
    refKey = key;
endtask

task automatic releaseKey();
    sendByte(`KEY_BREAK);
    sendByte(refKey);
    refKey = 8'h00;
endtask

task automatic waitBus(input string testName, input logic level);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (wbCyc !== level && cycles < 2 * frameCycles)
    begin
        @(negedge clock);
        cycles++;
    end
    if (wbCyc !== level)
        stopOnTimeout(testName, level ? "a redraw to start" : "a redraw to end");
endtask

task automatic waitState(input string testName, input controlPkg::gameState wanted);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (state !== wanted && cycles < 20)
    begin
        @(negedge clock);
        cycles++;
    end
    if (state !== wanted)
        stopOnTimeout(testName, $sformatf("the game to reach state %0d", wanted));
endtask

task automatic checkQuiet(input string testName, input int cycles);
    int i;
    int busyCycles;
    busyCycles = 0;
    for (i = 0; i < cycles; i++)
    begin
        @(negedge clock);
        if (wbCyc !== 1'b0)
            busyCycles++;
    end
    checkValue(testName, "bus cycles while idle", 0, busyCycles);
endtask

// key bytes sent mid redraw take effect from the next frame
task automatic beginFrame(input string testName);
    waitBus(testName, 1'b1);
    stepModel();
endtask

task automatic endFrame(input string testName);
    waitBus(testName, 1'b0);
    checkRedraw(testName);
endtask

task automatic runFrames(input string testName, input int count);
    int i;
    for (i = 0; i < count; i++)
    begin
        beginFrame(testName);
        endFrame(testName);
    end
endtask

task automatic steerPaddle();
    controlPkg::scanCode wanted;
    int centre;
    centre = refPaddle + `PADDLE_WIDTH / 2;
    if (centre < refBallX)
        wanted = `KEY_RIGHT;
    else if (centre > refBallX)
        wanted = `KEY_LEFT;
    else
        wanted = 8'h00;
    if (wanted != refKey && wanted == 8'h00)
        releaseKey();
    else if (wanted != refKey)
        pressKey(wanted);
endtask

task automatic resetAndMenuTest();
    applyReset();
    checkQuiet("reset", 3 * frameCycles);
    checkValue("reset", "state", controlPkg::stateMenu, state);
    checkValue("reset", "score", 0, score);
    checkValue("reset", "lives", `START_LIVES, lives);
    // make, break, then the released key
    sendByte(`KEY_LEFT);
    sendByte(`KEY_BREAK);
    sendByte(`KEY_LEFT);
    checkQuiet("menu", 3 * frameCycles);
    checkValue("menu", "state", controlPkg::stateMenu, state);
endtask

task automatic startTest();
    pressKey(`KEY_SPACE);
    waitState("start", controlPkg::statePlay);
    runFrames("start", 4);
endtask

task automatic paddleTest();
    int target;
    beginFrame("paddle right");
    pressKey(`KEY_RIGHT);
    endFrame("paddle right");
    runFrames("paddle right", 20);
    target = (`PADDLE_START + 20 > `PADDLE_MAX) ? `PADDLE_MAX : `PADDLE_START + 20;
    checkValue("paddle right", "paddle column", target, drawnPaddle);
    // the key is still held on the frame that carries the release
    beginFrame("paddle stop");
    releaseKey();
    endFrame("paddle stop");
    runFrames("paddle stop", 3);
    checkValue("paddle stop", "paddle column", `PADDLE_START + 21, drawnPaddle);
    beginFrame("paddle clamp");
    pressKey(`KEY_RIGHT);
    endFrame("paddle clamp");
    runFrames("paddle clamp", 60);
    checkValue("paddle clamp", "paddle column", `PADDLE_MAX, drawnPaddle);
    beginFrame("paddle left");
    pressKey(`KEY_LEFT);
    endFrame("paddle left");
    runFrames("paddle left", 140);
    checkValue("paddle left", "paddle column", `PADDLE_MIN, drawnPaddle);
endtask

// paddle stays parked at the left wall, so every approach is a miss
task automatic trajectoryTest();
    int frames;
    frames = 0;
    while (refLives > 0 && frames < 800)
    begin
        runFrames("trajectory", 1);
        frames++;
    end
    checkValue("trajectory", "lives", 0, refLives);
    waitState("trajectory", controlPkg::stateLoss);
    checkQuiet("loss", 3 * frameCycles);
endtask

task automatic scoreTest();
    int frames;
    applyReset();
    pressKey(`KEY_SPACE);
    waitState("win", controlPkg::statePlay);
    frames = 0;
    while (refScore < winScore && frames < 1200)
    begin
        beginFrame("win");
        steerPaddle();
        endFrame("win");
        frames++;
    end
    checkValue("win", "model score", winScore, refScore);
    waitState("win", controlPkg::stateWin);
    checkValue("win", "score", winScore, score);
    checkQuiet("win", 3 * frameCycles);
endtask

// ==== dv/breakoutCoreTb.sv ====
`timescale 1ns/10ps
`include "breakout_defs.svh"

module breakoutCoreTb;

    localparam int frameCycles = 200;
    localparam int winScore = 3;

    logic clock = 1'b0;
    logic reset;
    controlPkg::scanCode scanByte;
    logic scanValid;
    logic wbAck = 1'b0;
    controlPkg::gameState state;
    controlPkg::scoreCount score;
    controlPkg::lifeCount lives;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    playfieldPkg::pixelAddress wbAdr;
    playfieldPkg::colour wbData;

    int errorCount = 0;
    logic [31:0] lcgState = 32'h1bdb9a9f;
    logic [1:0] waitLeft = 2'd0;
    int logAdr[$];
    int logData[$];
    int drawnPaddle;

    // reference model, positions after the latest frame
    int refPaddle;
    int refBallX;
    int refBallY;
    bit refLeft;
    bit refUp;
    int refLastPaddle;
    int refLastBallX;
    int refLastBallY;
    int refScore;
    int refLives;
    controlPkg::scanCode refKey;

    always #20 clock = ~clock;

    breakoutCore #(
        .frameCycles(frameCycles),
        .winScore(winScore)
    ) uut (
        .clock(clock),
        .reset(reset),
        .scanByte(scanByte),
        .scanValid(scanValid),
        .state(state),
        .score(score),
        .lives(lives),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbData(wbData),
        .wbAck(wbAck)
    );

    function automatic logic [31:0] nextRandom(input logic [31:0] value);
        return value * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int pixelOf(input int column, input int row);
        return row * `SCREEN_WIDTH + column;
    endfunction

    // frame buffer stand-in, each write acked after 0 to 3 idle cycles
    always @(posedge clock)
    begin
        if (!reset)
        begin
            wbAck <= 1'b0;
            waitLeft <= 2'd0;
        end
        else if (wbAck)
        begin
            wbAck <= 1'b0;
            logAdr.push_back(wbAdr);
            logData.push_back(wbData);
            lcgState = nextRandom(lcgState);
            waitLeft <= lcgState[31:30];
        end
        else if (wbStb)
        begin
            assert (wbCyc && wbWe)
            else
            begin
                errorCount++;
                $display("bus strobe raised without cycle or write enable");
            end
            if (waitLeft == 2'd0)
                wbAck <= 1'b1;
            else
                waitLeft <= waitLeft - 2'd1;
        end
    end

    task automatic checkValue(input string testName, input string what, input int expected,
        input int actual);
        assert (actual == expected)
        else
        begin
            errorCount++;
            $display("Error %s: %s expected %0d actual %0d", testName, what, expected, actual);
        end
    endtask

    task automatic finishRun();
        $display("Simulation done with %0d errors", errorCount);
        if (errorCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    endtask

    task automatic stopOnTimeout(input string testName, input string what);
        errorCount++;
        $display("%s: timed out waiting for %s", testName, what);
        finishRun();
    endtask

    function automatic void restartBall();
        refBallX = `BALL_START_X;
        refBallY = `BALL_START_Y;
        refLeft = 1'b1;
        refUp = 1'b1;
    endfunction

    function automatic void resetModel();
        restartBall();
        refPaddle = `PADDLE_START;
        refLastPaddle = `PADDLE_START;
        refLastBallX = `BALL_START_X;
        refLastBallY = `BALL_START_Y;
        refScore = 0;
        refLives = `START_LIVES;
        refKey = 8'h00;
    endfunction

    // one frame of motion, the ball sees the paddle from before the frame
    function automatic void stepModel();
        int nextX;
        if (refBallX == 0)
            refLeft = 1'b0;
        else if (refBallX == `SCREEN_WIDTH - 1)
            refLeft = 1'b1;
        nextX = refLeft ? refBallX - 1 : refBallX + 1;
        if (!refUp && refBallY == `SCREEN_HEIGHT - 1)
        begin
            refLives--;
            restartBall();
        end
        else
        begin
            if (refBallY == 0)
                refUp = 1'b0;
            else if (!refUp && refBallY == `PADDLE_ROW - 1 && nextX >= refPaddle
                && nextX < refPaddle + `PADDLE_WIDTH)
            begin
                refUp = 1'b1;
                refScore++;
            end
            refBallX = nextX;
            refBallY = refUp ? refBallY - 1 : refBallY + 1;
        end
        if (refKey == `KEY_RIGHT && refPaddle < `PADDLE_MAX)
            refPaddle++;
        else if (refKey == `KEY_LEFT && refPaddle > `PADDLE_MIN)
            refPaddle--;
    endfunction

    // erase old ball, erase old paddle, draw paddle, draw ball
    task automatic checkRedraw(input string testName);
        int expAdr[42];
        int expData[42];
        int i;
        expAdr[0] = pixelOf(refLastBallX, refLastBallY);
        expData[0] = `COLOUR_BLACK;
        for (i = 0; i < `PADDLE_WIDTH; i++)
        begin
            expAdr[1 + i] = pixelOf(refLastPaddle + i, `PADDLE_ROW);
            expData[1 + i] = `COLOUR_BLACK;
            expAdr[21 + i] = pixelOf(refPaddle + i, `PADDLE_ROW);
            expData[21 + i] = `COLOUR_PADDLE;
        end
        expAdr[41] = pixelOf(refBallX, refBallY);
        expData[41] = `COLOUR_BALL;
        checkValue(testName, "writes in redraw", 42, logAdr.size());
        if (logAdr.size() == 42)
        begin
            for (i = 0; i < 42; i++)
            begin
                checkValue(testName, $sformatf("address of write %0d", i), expAdr[i], logAdr[i]);
                checkValue(testName, $sformatf("colour of write %0d", i), expData[i], logData[i]);
            end
            drawnPaddle = logAdr[21] - pixelOf(0, `PADDLE_ROW);
        end
        checkValue(testName, "score", refScore, score);
        checkValue(testName, "lives", refLives, lives);
        logAdr.delete();
        logData.delete();
        refLastPaddle = refPaddle;
        refLastBallX = refBallX;
        refLastBallY = refBallY;
    endtask

    `include "breakoutTests.svh"

    initial
    begin
        reset = 1'b0;
        scanByte = 8'h00;
        scanValid = 1'b0;
        resetModel();
        resetAndMenuTest();
        startTest();
        paddleTest();
        trajectoryTest();
        scoreTest();
        finishRun();
    end

endmodule

// ==== breakoutCore.f ====
+incdir+source
+incdir+dv
source/playfieldPkg.sv
source/controlPkg.sv
source/keyDecoder.sv
source/frameTimer.sv
source/paddleMotion.sv
source/ballMotion.sv
source/gameControl.sv
source/pixelWriter.sv
source/breakoutCore.sv
dv/breakoutCoreTb.sv
